/* Makefile */
VERILATOR ?= verilator
TOP       ?= cfg_mem_subsys_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cfg_mem_subsys_tb.sv */
// testbench for the split cfg memory: reference model, xorshift source, directed tests, watchdog
`default_nettype none

module cfg_mem_subsys_tb
  import cfg_mem_pkg::*;
();

  // ====================
  // run limits
  // ====================

  // memory operations issued over all tests
  localparam int NUM_OPS         = 63;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 100;
  localparam int PIPE_READS      = 16;

  logic                    clk;
  logic                    rst_n;
  logic                    cfg_req;
  cfg_op_t                 cfg_op;
  logic [CFG_AWIDTH-1:0]   cfg_addr;
  logic [SLICE_DWIDTH-1:0] cfg_wdata;
  logic                    cfg_done;
  logic [SLICE_DWIDTH-1:0] cfg_rdata;
  logic                    cfg_busy;
  logic                    func_req;
  logic                    func_write;
  logic [MEM_AWIDTH-1:0]   func_addr;
  logic [FUNC_DWIDTH-1:0]  func_wdata;
  logic                    func_rvalid;
  logic [FUNC_DWIDTH-1:0]  func_rdata;

  // reference copy of the whole memory, slice s of a word sits at bits s*33 upward
  logic [FUNC_DWIDTH-1:0]  model_mem [MEM_DEPTH];
  logic [31:0]             rng_state;
  int                      test_errors;
  int                      total_errors;
  int                      tests_run;
  int                      tests_failed;

  cfg_mem_subsys i_cfg_mem_subsys (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_req     (cfg_req),
    .cfg_op      (cfg_op),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_done    (cfg_done),
    .cfg_rdata   (cfg_rdata),
    .cfg_busy    (cfg_busy),
    .func_req    (func_req),
    .func_write  (func_write),
    .func_addr   (func_addr),
    .func_wdata  (func_wdata),
    .func_rvalid (func_rvalid),
    .func_rdata  (func_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand_slice(output logic [SLICE_DWIDTH-1:0] v);
    logic [31:0] lo;
    rng_state = xorshift32(rng_state);
    lo = rng_state;
    rng_state = xorshift32(rng_state);
    v = {rng_state[0], lo};
  endtask

  task automatic rand_word(output logic [FUNC_DWIDTH-1:0] v);
    logic [31:0] a;
    logic [31:0] b;
    rng_state = xorshift32(rng_state);
    a = rng_state;
    rng_state = xorshift32(rng_state);
    b = rng_state;
    rng_state = xorshift32(rng_state);
    v = {rng_state[1:0], b, a};
  endtask

  task automatic rand_addr(output logic [MEM_AWIDTH-1:0] a);
    rng_state = xorshift32(rng_state);
    a = rng_state[MEM_AWIDTH-1:0];
  endtask

  // cfg address: bit 0 picks the slice, the rest is the word
  task automatic model_write_slice(input logic [CFG_AWIDTH-1:0] a,
                                   input logic [SLICE_DWIDTH-1:0] d);
    model_mem[a[CFG_AWIDTH-1:1]][int'(a[0]) * SLICE_DWIDTH +: SLICE_DWIDTH] = d;
  endtask

  function automatic logic [SLICE_DWIDTH-1:0] model_read_slice(input logic [CFG_AWIDTH-1:0] a);
    return model_mem[a[CFG_AWIDTH-1:1]][int'(a[0]) * SLICE_DWIDTH +: SLICE_DWIDTH];
  endfunction

  task automatic check_val(input string name, input logic [FUNC_DWIDTH-1:0] exp,
                           input logic [FUNC_DWIDTH-1:0] got);
    assert (got === exp) else begin
      $display("FAILED %s expected 0x%h got 0x%h", name, exp, got);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %s finished with %0d errors", name, test_errors);
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // drive and sample point, just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // one cfg access, returns read data and cycles from cfg_req to cfg_done
  task automatic cfg_access(input cfg_op_t op, input logic [CFG_AWIDTH-1:0] a,
                            input logic [SLICE_DWIDTH-1:0] d,
                            output logic [SLICE_DWIDTH-1:0] rd, output int lat);
    cfg_req   = 1'b1;
    cfg_op    = op;
    cfg_addr  = a;
    cfg_wdata = d;
    tick();
    cfg_req = 1'b0;
    lat = 1;
    while (!cfg_done && lat < 20) begin
      tick();
      lat++;
    end
    assert (cfg_done) else begin
      $display("cfg_done did not arrive within 20 cycles of cfg_req");
      test_errors++;
    end
    rd = cfg_rdata;
    // sequencer is back in idle one cycle after done
    tick();
  endtask

  task automatic func_write_word(input logic [MEM_AWIDTH-1:0] a,
                                 input logic [FUNC_DWIDTH-1:0] d);
    func_req   = 1'b1;
    func_write = 1'b1;
    func_addr  = a;
    func_wdata = d;
    model_mem[a] = d;
    tick();
    func_req   = 1'b0;
    func_write = 1'b0;
  endtask

  task automatic func_read_word(input logic [MEM_AWIDTH-1:0] a,
                                output logic [FUNC_DWIDTH-1:0] rd, output int lat);
    func_req   = 1'b1;
    func_write = 1'b0;
    func_addr  = a;
    tick();
    func_req = 1'b0;
    lat = 1;
    while (!func_rvalid && lat < 20) begin
      tick();
      lat++;
    end
    assert (func_rvalid) else begin
      $display("func_rvalid did not arrive within 20 cycles of func_req");
      test_errors++;
    end
    rd = func_rdata;
    tick();
  endtask

  // ====================
  // tests
  // ====================

  task automatic test_reset();
    check_val("cfg_done", '0, FUNC_DWIDTH'(cfg_done));
    check_val("cfg_busy", '0, FUNC_DWIDTH'(cfg_busy));
    check_val("func_rvalid", '0, FUNC_DWIDTH'(func_rvalid));
    finish_test("reset");
  endtask

  task automatic test_cfg_round_trip();
    logic [MEM_AWIDTH-1:0]   w;
    logic [CFG_AWIDTH-1:0]   a;
    logic [SLICE_DWIDTH-1:0] d;
    logic [SLICE_DWIDTH-1:0] rd;
    int                      lat;
    for (int s = 0; s < NUM_SLICES; s++) begin
      rand_addr(w);
      rand_slice(d);
      a = {w, 1'(s)};
      cfg_access(CFG_OP_WRITE, a, d, rd, lat);
      model_write_slice(a, d);
      check_val("cfg_done latency", FUNC_DWIDTH'(4), FUNC_DWIDTH'(lat));
      cfg_access(CFG_OP_READ, a, '0, rd, lat);
      check_val("cfg_rdata", FUNC_DWIDTH'(model_read_slice(a)), FUNC_DWIDTH'(rd));
      check_val("cfg_done latency", FUNC_DWIDTH'(4), FUNC_DWIDTH'(lat));
    end
    finish_test("cfg_round_trip");
  endtask

  task automatic test_func_to_cfg();
    logic [MEM_AWIDTH-1:0]   w;
    logic [FUNC_DWIDTH-1:0]  d;
    logic [SLICE_DWIDTH-1:0] rd;
    int                      lat;
    rand_addr(w);
    rand_word(d);
    func_write_word(w, d);
    tick();
    // each cfg read returns one half of the functional word
    for (int s = 0; s < NUM_SLICES; s++) begin
      cfg_access(CFG_OP_READ, {w, 1'(s)}, '0, rd, lat);
      check_val("cfg_rdata", FUNC_DWIDTH'(model_read_slice({w, 1'(s)})), FUNC_DWIDTH'(rd));
    end
    finish_test("func_to_cfg");
  endtask

  task automatic test_cfg_to_func();
    logic [MEM_AWIDTH-1:0]   w;
    logic [SLICE_DWIDTH-1:0] d;
    logic [SLICE_DWIDTH-1:0] rd;
    logic [FUNC_DWIDTH-1:0]  word;
    int                      lat;
    rand_addr(w);
    for (int s = 0; s < NUM_SLICES; s++) begin
      rand_slice(d);
      cfg_access(CFG_OP_WRITE, {w, 1'(s)}, d, rd, lat);
      model_write_slice({w, 1'(s)}, d);
    end
    func_read_word(w, word, lat);
    check_val("func_rdata", model_mem[w], word);
    check_val("func_rvalid latency", FUNC_DWIDTH'(3), FUNC_DWIDTH'(lat));
    finish_test("cfg_to_func");
  endtask

  task automatic test_func_pipeline();
    logic [MEM_AWIDTH-1:0]  w;
    logic [FUNC_DWIDTH-1:0] d;
    logic [FUNC_DWIDTH-1:0] exp_q [$];
    int                     got;
    // fill every word back to back
    for (int i = 0; i < MEM_DEPTH; i++) begin
      rand_word(d);
      func_write_word(MEM_AWIDTH'(i), d);
    end
    got = 0;
    for (int i = 0; i < PIPE_READS + 4; i++) begin
      // responses come back in issue order
      if (func_rvalid) begin
        assert (exp_q.size() != 0) else begin
          $display("func_rvalid arrived with no read outstanding");
          test_errors++;
        end
        if (exp_q.size() != 0) check_val("func_rdata", exp_q.pop_front(), func_rdata);
        got++;
      end
      if (i < PIPE_READS) begin
        rand_addr(w);
        func_req   = 1'b1;
        func_write = 1'b0;
        func_addr  = w;
        exp_q.push_back(model_mem[w]);
      end else begin
        func_req = 1'b0;
      end
      tick();
    end
    assert (got == PIPE_READS) else begin
      $display("expected %0d read responses but saw %0d", PIPE_READS, got);
      test_errors++;
    end
    finish_test("func_pipeline");
  endtask

  task automatic test_req_while_busy();
    logic [CFG_AWIDTH-1:0]   a;
    logic [CFG_AWIDTH-1:0]   b;
    logic [SLICE_DWIDTH-1:0] d;
    logic [SLICE_DWIDTH-1:0] rd;
    int                      lat;
    int                      dones;
    a = 6'd10;
    b = 6'd21;
    rand_slice(d);
    cfg_access(CFG_OP_WRITE, b, d, rd, lat);
    model_write_slice(b, d);
    // accepted write to a, then a second write to b two cycles later
    rand_slice(d);
    cfg_req   = 1'b1;
    cfg_op    = CFG_OP_WRITE;
    cfg_addr  = a;
    cfg_wdata = d;
    model_write_slice(a, d);
    tick();
    cfg_req = 1'b0;
    tick();
    check_val("cfg_busy", FUNC_DWIDTH'(1), FUNC_DWIDTH'(cfg_busy));
    cfg_req   = 1'b1;
    cfg_addr  = b;
    cfg_wdata = ~d;
    tick();
    cfg_req = 1'b0;
    dones = 0;
    for (int i = 0; i < 10; i++) begin
      if (cfg_done) dones++;
      tick();
    end
    check_val("cfg_done count", FUNC_DWIDTH'(1), FUNC_DWIDTH'(dones));
    cfg_access(CFG_OP_READ, b, '0, rd, lat);
    check_val("cfg_rdata", FUNC_DWIDTH'(model_read_slice(b)), FUNC_DWIDTH'(rd));
    cfg_access(CFG_OP_READ, a, '0, rd, lat);
    check_val("cfg_rdata", FUNC_DWIDTH'(model_read_slice(a)), FUNC_DWIDTH'(rd));
    finish_test("req_while_busy");
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    rng_state    = 32'd3276;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n      = 1'b0;
    cfg_req    = 1'b0;
    cfg_op     = CFG_OP_READ;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    func_req   = 1'b0;
    func_write = 1'b0;
    func_addr  = '0;
    func_wdata = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    test_reset();
    test_cfg_round_trip();
    test_func_to_cfg();
    test_cfg_to_func();
    test_func_pipeline();
    test_req_while_busy();
    $display("tests run %0d, tests with errors %0d, total errors %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // stops a run that hangs on a missing strobe
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/cfg_mem_pkg.sv
verilog/ram_slice_access.sv
verilog/cfg_req_sequencer.sv
verilog/cfg_mem_split.sv
verilog/func_access_port.sv
verilog/cfg_mem_subsys.sv
dv/cfg_mem_subsys_tb.sv

/* verilog/cfg_mem_pkg.sv */
// memory geometry constants, configuration opcode enum and sequencer state enum
`default_nettype none

package cfg_mem_pkg;

  // ====================
  // geometry
  // ====================

  // log2 of the slice count
  localparam int SLICE_FACTOR = 1;
  localparam int NUM_SLICES   = 1 << SLICE_FACTOR;

  // one slice word, check bits included but not interpreted
  localparam int SLICE_DWIDTH = 33;

  // word address into each slice
  localparam int MEM_AWIDTH   = 5;
  localparam int MEM_DEPTH    = 1 << MEM_AWIDTH;

  // whole functional word spans every slice
  localparam int FUNC_DWIDTH  = NUM_SLICES * SLICE_DWIDTH;

  // cfg address: slice select in the low bits, word address above
  localparam int CFG_AWIDTH   = SLICE_FACTOR + MEM_AWIDTH;

  // ====================
  // enums
  // ====================

  typedef enum logic {
    CFG_OP_READ  = 1'b0,
    CFG_OP_WRITE = 1'b1
  } cfg_op_t;

  // request sequencer states
  typedef enum logic [1:0] {
    CFG_IDLE  = 2'd0,
    CFG_ISSUE = 2'd1,
    CFG_WAIT  = 2'd2,
    CFG_DONE  = 2'd3
  } cfg_state_t;

endpackage

`default_nettype wire

/* verilog/cfg_mem_split.sv */
// steering of cfg and functional accesses onto the slices, cfg ack generation
`default_nettype none

module cfg_mem_split
  import cfg_mem_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  // cfg side, one slice word at a time
  input  logic                    cfg_mem_re,
  input  logic                    cfg_mem_we,
  input  logic [CFG_AWIDTH-1:0]   cfg_mem_addr,
  input  logic [SLICE_DWIDTH-1:0] cfg_mem_wdata,
  output logic [SLICE_DWIDTH-1:0] cfg_mem_rdata,
  output logic                    cfg_mem_ack,
  // functional side, whole words
  input  logic                    mem_read,
  input  logic                    mem_write,
  input  logic [MEM_AWIDTH-1:0]   mem_addr,
  input  logic [FUNC_DWIDTH-1:0]  mem_wdata,
  output logic [FUNC_DWIDTH-1:0]  mem_rdata,
  // slice side
  output logic [NUM_SLICES-1:0]   slice_re,
  output logic [NUM_SLICES-1:0]   slice_we,
  output logic [MEM_AWIDTH-1:0]   slice_addr,
  output logic [FUNC_DWIDTH-1:0]  slice_wdata,
  input  logic [FUNC_DWIDTH-1:0]  slice_rdata,
  input  logic [NUM_SLICES-1:0]   acc_re,
  input  logic [NUM_SLICES-1:0]   acc_we
);

  logic [SLICE_FACTOR-1:0] cfg_sel;
  logic [SLICE_FACTOR-1:0] sel_q;
  logic                    ack_pend_q;
  logic                    ack_pend_nxt;
  logic                    ack_q;
  logic                    ack_nxt;
  logic                    acc_re_any;
  logic                    acc_we_any;

  // low cfg address bits pick the slice
  assign cfg_sel = cfg_mem_addr[SLICE_FACTOR-1:0];

  // ====================
  // steering
  // ====================

  always_comb begin
    slice_re    = '0;
    slice_we    = '0;
    slice_addr  = mem_addr;
    slice_wdata = mem_wdata;
    if (cfg_mem_we) begin
      // only the chosen slice writes, data replicated to all lanes
      for (int i = 0; i < NUM_SLICES; i++) begin
        if (cfg_sel == i[SLICE_FACTOR-1:0]) slice_we[i] = 1'b1;
      end
      slice_addr  = cfg_mem_addr[SLICE_FACTOR +: MEM_AWIDTH];
      slice_wdata = {NUM_SLICES{cfg_mem_wdata}};
    end else if (cfg_mem_re) begin
      for (int i = 0; i < NUM_SLICES; i++) begin
        if (cfg_sel == i[SLICE_FACTOR-1:0]) slice_re[i] = 1'b1;
      end
      slice_addr = cfg_mem_addr[SLICE_FACTOR +: MEM_AWIDTH];
    end else begin
      // functional access goes to every slice
      slice_re = {NUM_SLICES{mem_read}};
      slice_we = {NUM_SLICES{mem_write}};
    end
  end

  // ====================
  // cfg acknowledge
  // ====================

  assign acc_re_any = |acc_re;
  assign acc_we_any = |acc_we;

  always_comb begin
    ack_pend_nxt = ack_pend_q;
    if (acc_re_any || acc_we_any) ack_pend_nxt = 1'b0;
    // pending from the strobe until its slice access pulses
    if (cfg_mem_re || cfg_mem_we) ack_pend_nxt = 1'b1;
    ack_nxt = ack_pend_q && (acc_re_any || acc_we_any);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q      <= '0;
      ack_pend_q <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      if (cfg_mem_re) sel_q <= cfg_sel;
      ack_pend_q <= ack_pend_nxt;
      ack_q      <= ack_nxt;
    end
  end

  assign cfg_mem_ack   = ack_q;
  // slice holds its read data, so the registered select is enough
  assign cfg_mem_rdata = slice_rdata[sel_q * SLICE_DWIDTH +: SLICE_DWIDTH];
  assign mem_rdata     = slice_rdata;

  // no functional traffic from the cfg strobe until its slice access is done
  a_no_func_during_cfg : assert property (@(posedge clk) disable iff (!rst_n)
    (cfg_mem_re || cfg_mem_we || ack_pend_q) |-> !(mem_read || mem_write));

  a_cfg_one_slice : assert property (@(posedge clk) disable iff (!rst_n)
    (cfg_mem_re || cfg_mem_we) |-> $onehot0(slice_re | slice_we));

endmodule

`default_nettype wire

/* verilog/cfg_mem_subsys.sv */
// top level: sequencer, split block, storage slices and functional port
`default_nettype none

module cfg_mem_subsys
  import cfg_mem_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  // cfg port
  input  logic                    cfg_req,
  input  cfg_op_t                 cfg_op,
  input  logic [CFG_AWIDTH-1:0]   cfg_addr,
  input  logic [SLICE_DWIDTH-1:0] cfg_wdata,
  output logic                    cfg_done,
  output logic [SLICE_DWIDTH-1:0] cfg_rdata,
  output logic                    cfg_busy,
  // functional port
  input  logic                    func_req,
  input  logic                    func_write,
  input  logic [MEM_AWIDTH-1:0]   func_addr,
  input  logic [FUNC_DWIDTH-1:0]  func_wdata,
  output logic                    func_rvalid,
  output logic [FUNC_DWIDTH-1:0]  func_rdata
);

  // sequencer to split
  logic                    cfg_mem_re;
  logic                    cfg_mem_we;
  logic [CFG_AWIDTH-1:0]   cfg_mem_addr;
  logic [SLICE_DWIDTH-1:0] cfg_mem_wdata;
  logic [SLICE_DWIDTH-1:0] cfg_mem_rdata;
  logic                    cfg_mem_ack;
  // functional port to split
  logic                    mem_read;
  logic                    mem_write;
  logic [MEM_AWIDTH-1:0]   mem_addr;
  logic [FUNC_DWIDTH-1:0]  mem_wdata;
  logic [FUNC_DWIDTH-1:0]  mem_rdata;
  // split to slices
  logic [NUM_SLICES-1:0]   slice_re;
  logic [NUM_SLICES-1:0]   slice_we;
  logic [MEM_AWIDTH-1:0]   slice_addr;
  logic [FUNC_DWIDTH-1:0]  slice_wdata;
  logic [FUNC_DWIDTH-1:0]  slice_rdata;
  logic [NUM_SLICES-1:0]   acc_re;
  logic [NUM_SLICES-1:0]   acc_we;

  cfg_req_sequencer i_cfg_req_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_req       (cfg_req),
    .cfg_op        (cfg_op),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_mem_rdata (cfg_mem_rdata),
    .cfg_mem_ack   (cfg_mem_ack),
    .cfg_done      (cfg_done),
    .cfg_rdata     (cfg_rdata),
    .cfg_busy      (cfg_busy),
    .cfg_mem_re    (cfg_mem_re),
    .cfg_mem_we    (cfg_mem_we),
    .cfg_mem_addr  (cfg_mem_addr),
    .cfg_mem_wdata (cfg_mem_wdata)
  );

  cfg_mem_split i_cfg_mem_split (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_mem_re    (cfg_mem_re),
    .cfg_mem_we    (cfg_mem_we),
    .cfg_mem_addr  (cfg_mem_addr),
    .cfg_mem_wdata (cfg_mem_wdata),
    .cfg_mem_rdata (cfg_mem_rdata),
    .cfg_mem_ack   (cfg_mem_ack),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .slice_re      (slice_re),
    .slice_we      (slice_we),
    .slice_addr    (slice_addr),
    .slice_wdata   (slice_wdata),
    .slice_rdata   (slice_rdata),
    .acc_re        (acc_re),
    .acc_we        (acc_we)
  );

  // one slice per data lane, all share the word address
  for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
    ram_slice_access i_ram_slice_access (
      .clk    (clk),
      .rst_n  (rst_n),
      .re     (slice_re[i]),
      .we     (slice_we[i]),
      .addr   (slice_addr),
      .wdata  (slice_wdata[i*SLICE_DWIDTH +: SLICE_DWIDTH]),
      .rdata  (slice_rdata[i*SLICE_DWIDTH +: SLICE_DWIDTH]),
      .acc_re (acc_re[i]),
      .acc_we (acc_we[i])
    );
  end

  func_access_port i_func_access_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .func_req    (func_req),
    .func_write  (func_write),
    .func_addr   (func_addr),
    .func_wdata  (func_wdata),
    .mem_rdata   (mem_rdata),
    .func_rvalid (func_rvalid),
    .func_rdata  (func_rdata),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata)
  );

endmodule

`default_nettype wire

/* verilog/cfg_req_sequencer.sv */
// configuration request sequencer: one slice access at a time, returns data and done
`default_nettype none

module cfg_req_sequencer
  import cfg_mem_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_req,
  input  cfg_op_t                 cfg_op,
  input  logic [CFG_AWIDTH-1:0]   cfg_addr,
  input  logic [SLICE_DWIDTH-1:0] cfg_wdata,
  input  logic [SLICE_DWIDTH-1:0] cfg_mem_rdata,
  input  logic                    cfg_mem_ack,
  output logic                    cfg_done,
  output logic [SLICE_DWIDTH-1:0] cfg_rdata,
  output logic                    cfg_busy,
  output logic                    cfg_mem_re,
  output logic                    cfg_mem_we,
  output logic [CFG_AWIDTH-1:0]   cfg_mem_addr,
  output logic [SLICE_DWIDTH-1:0] cfg_mem_wdata
);

  cfg_state_t              state_q;
  cfg_state_t              state_nxt;
  cfg_op_t                 op_q;
  logic [CFG_AWIDTH-1:0]   addr_q;
  logic [SLICE_DWIDTH-1:0] wdata_q;

  // ====================
  // state machine
  // ====================

  always_comb begin
    state_nxt = state_q;
    unique case (state_q)
      // requests are only taken here, anything else is dropped
      CFG_IDLE:  if (cfg_req) state_nxt = CFG_ISSUE;
      // strobe lasts exactly this one cycle
      CFG_ISSUE: state_nxt = CFG_WAIT;
      CFG_WAIT:  if (cfg_mem_ack) state_nxt = CFG_DONE;
      CFG_DONE:  state_nxt = CFG_IDLE;
      default:   state_nxt = CFG_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CFG_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // latch the accepted request
  always_ff @(posedge clk) begin
    if (state_q == CFG_IDLE && cfg_req) begin
      op_q    <= cfg_op;
      addr_q  <= cfg_addr;
      wdata_q <= cfg_wdata;
    end
  end

  // read data is held by the slice while the ack is up
  always_ff @(posedge clk) begin
    if (state_q == CFG_WAIT && cfg_mem_ack) begin
      cfg_rdata <= cfg_mem_rdata;
    end
  end

  // ====================
  // outputs
  // ====================

  assign cfg_mem_re    = (state_q == CFG_ISSUE) && (op_q == CFG_OP_READ);
  assign cfg_mem_we    = (state_q == CFG_ISSUE) && (op_q == CFG_OP_WRITE);
  assign cfg_mem_addr  = addr_q;
  assign cfg_mem_wdata = wdata_q;
  assign cfg_done      = (state_q == CFG_DONE);
  // busy covers issue through done
  assign cfg_busy      = (state_q != CFG_IDLE);

  // ack only makes sense once the slice access has been sent out
  a_no_early_ack : assert property (@(posedge clk) disable iff (!rst_n)
    cfg_mem_ack |-> !(state_q inside {CFG_IDLE, CFG_ISSUE}));

endmodule

`default_nettype wire

/* verilog/func_access_port.sv */
// functional access port: registered whole-word requests, aligned read responses
`default_nettype none

module func_access_port
  import cfg_mem_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   func_req,
  input  logic                   func_write,
  input  logic [MEM_AWIDTH-1:0]  func_addr,
  input  logic [FUNC_DWIDTH-1:0] func_wdata,
  input  logic [FUNC_DWIDTH-1:0] mem_rdata,
  output logic                   func_rvalid,
  output logic [FUNC_DWIDTH-1:0] func_rdata,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic [MEM_AWIDTH-1:0]  mem_addr,
  output logic [FUNC_DWIDTH-1:0] mem_wdata
);

  // stage 0 is the slice access cycle, stage 1 the response cycle
  logic [1:0] rd_vld_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
      rd_vld_q  <= '0;
    end else begin
      mem_read  <= func_req && !func_write;
      mem_write <= func_req && func_write;
      rd_vld_q  <= {rd_vld_q[0], mem_read};
    end
  end

  // address and data follow the strobe
  always_ff @(posedge clk) begin
    mem_addr  <= func_addr;
    mem_wdata <= func_wdata;
    // capture the word while the slices present it
    if (rd_vld_q[0]) func_rdata <= mem_rdata;
  end

  assign func_rvalid = rd_vld_q[1];

endmodule

`default_nettype wire

/* verilog/ram_slice_access.sv */
// storage slice with registered access stage, held read data and access pulses
`default_nettype none

module ram_slice_access
  import cfg_mem_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    re,
  input  logic                    we,
  input  logic [MEM_AWIDTH-1:0]   addr,
  input  logic [SLICE_DWIDTH-1:0] wdata,
  output logic [SLICE_DWIDTH-1:0] rdata,
  output logic                    acc_re,
  output logic                    acc_we
);

  logic [SLICE_DWIDTH-1:0] mem [MEM_DEPTH];
  logic                    re_q;
  logic                    we_q;
  logic [MEM_AWIDTH-1:0]   addr_q;
  logic [SLICE_DWIDTH-1:0] wdata_q;
  logic [SLICE_DWIDTH-1:0] rdata_q;

  // request stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      re_q <= 1'b0;
      we_q <= 1'b0;
    end else begin
      re_q <= re;
      we_q <= we;
    end
  end

  always_ff @(posedge clk) begin
    addr_q  <= addr;
    wdata_q <= wdata;
  end

  // ====================
  // array access
  // ====================

  always_ff @(posedge clk) begin
    if (we_q) mem[addr_q] <= wdata_q;
    // hold register keeps the last read word
    if (re_q) rdata_q <= mem[addr_q];
  end

  // read word is visible in the access cycle, then held
  assign rdata  = re_q ? mem[addr_q] : rdata_q;
  assign acc_re = re_q;
  assign acc_we = we_q;

  a_no_rd_wr_same_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    !(re && we));

endmodule

`default_nettype wire
